// File: common/sat_lvl_pkg.sv
// Shared widths, types and encodings of the level-state store.
// The level count is fixed here and must stay even, since levels are kept in pairs.
`default_nettype none

package sat_lvl_pkg;

    localparam int NUM_LVLS  = 8;
    localparam int NUM_PAIRS = NUM_LVLS / 2;
    localparam int WIDTH_BIN = 10;
    localparam int WIDTH_LVL = 3;

    typedef logic [WIDTH_BIN-1:0] bin_t;       // decided bin number.
    typedef logic [WIDTH_LVL-1:0] lvl_t;       // decision level index.
    typedef logic [NUM_LVLS-1:0]  lvl_mask_t;  // one bit per level.

    // state kept for one decision level.
    typedef struct packed {
        bin_t dcd_bin;
        logic has_bkt;
    } lvl_state_t;

    // find flag that ripples from the top level down to level 0.
    typedef enum logic [1:0] {
        FIND_SEARCH = 2'd0,  // no level found yet.
        FIND_HIT    = 2'd1,  // this cell is the backtrack level.
        FIND_DONE   = 2'd2   // the hit lies above.
    } findflag_t;

endpackage

`default_nettype wire

// File: src/lvl_cmd_decode.sv
// Registers the engine requests and turns level indices into one-hot write strobes.
// A decide and a load to the same level in one cycle resolve to the decide.
`timescale 1ns/1ps
`default_nettype none

module lvl_cmd_decode (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         decide_i,
    input  wire sat_lvl_pkg::lvl_t      dcd_lvl_i,
    input  wire sat_lvl_pkg::bin_t      dcd_bin_i,
    input  wire                         bkt_req_i,
    input  wire sat_lvl_pkg::lvl_t      max_lvl_i,
    input  wire                         ld_i,
    input  wire sat_lvl_pkg::lvl_t      ld_lvl_i,
    input  wire sat_lvl_pkg::lvl_state_t ld_state_i,
    output sat_lvl_pkg::lvl_mask_t      dcd_wr_o,
    output sat_lvl_pkg::bin_t           dcd_bin_o,
    output sat_lvl_pkg::lvl_mask_t      ld_wr_o,
    output sat_lvl_pkg::lvl_state_t     ld_state_o,
    output logic                        apply_bkt_o,
    output sat_lvl_pkg::lvl_mask_t      in_range_o
);

    import sat_lvl_pkg::*;

    lvl_mask_t dcd_oh;
    lvl_mask_t ld_oh;
    lvl_mask_t range_d;

    always_comb begin
        dcd_oh  = '0;
        ld_oh   = '0;
        range_d = '0;
        for (int i = 0; i < NUM_LVLS; i++) begin
            dcd_oh[i]  = decide_i && (dcd_lvl_i == lvl_t'(i));
            ld_oh[i]   = ld_i && (ld_lvl_i == lvl_t'(i));
            range_d[i] = (lvl_t'(i) <= max_lvl_i);  // thermometer up to max level.
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dcd_wr_o    <= '0;
            ld_wr_o     <= '0;
            apply_bkt_o <= 1'b0;
            in_range_o  <= '0;
        end else begin
            dcd_wr_o    <= dcd_oh;
            ld_wr_o     <= ld_oh & ~dcd_oh;  // decide wins over load.
            apply_bkt_o <= bkt_req_i;
            in_range_o  <= range_d;
        end
    end

    // payload registers, valid together with their strobes.
    always_ff @(posedge clk) begin
        if (decide_i) begin
            dcd_bin_o <= dcd_bin_i;
        end
        if (ld_i) begin
            ld_state_o <= ld_state_i;
        end
    end

endmodule

`default_nettype wire

// File: lvl_state/lvl_state_cell.sv
// One decision level: its stored state, its step of the find chain and its backtrack.
// The bin output is zero unless this cell is the hit.
`timescale 1ns/1ps
`default_nettype none

module lvl_state_cell (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          dcd_wr_i,
    input  wire sat_lvl_pkg::bin_t       dcd_bin_i,
    input  wire                          ld_wr_i,
    input  wire sat_lvl_pkg::lvl_state_t ld_state_i,
    input  wire                          apply_bkt_i,
    input  wire                          in_range_i,
    input  wire sat_lvl_pkg::findflag_t  findflag_i,
    output sat_lvl_pkg::findflag_t       findflag_o,
    output logic                         hit_o,
    output sat_lvl_pkg::bin_t            bkt_bin_o,
    output sat_lvl_pkg::lvl_state_t      state_o
);

    import sat_lvl_pkg::*;

    lvl_state_t state_q;

    always_comb begin
        case (findflag_i)
            FIND_SEARCH: begin
                if (in_range_i && !state_q.has_bkt) begin
                    findflag_o = FIND_HIT;
                end else begin
                    findflag_o = FIND_SEARCH;
                end
            end
            default: findflag_o = FIND_DONE;  // a hit was found above.
        endcase
    end

    assign hit_o     = (findflag_o == FIND_HIT);
    assign bkt_bin_o = hit_o ? state_q.dcd_bin : '0;
    assign state_o   = state_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= '0;
        end else if (dcd_wr_i) begin
            state_q.dcd_bin <= dcd_bin_i;
            state_q.has_bkt <= 1'b0;  // a fresh decision is not backtracked.
        end else if (ld_wr_i) begin
            state_q <= ld_state_i;
        end else if (apply_bkt_i && hit_o) begin
            state_q.has_bkt <= 1'b1;  // bin kept, engine flips it.
        end
    end

endmodule

`default_nettype wire

// File: lvl_state/lvl_state2.sv
// Two adjacent levels; the upper cell feeds its find flag into the lower one.
`timescale 1ns/1ps
`default_nettype none

module lvl_state2 (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire [1:0]                    dcd_wr_i,
    input  wire sat_lvl_pkg::bin_t       dcd_bin_i,
    input  wire [1:0]                    ld_wr_i,
    input  wire sat_lvl_pkg::lvl_state_t ld_state_i,
    input  wire                          apply_bkt_i,
    input  wire [1:0]                    in_range_i,
    input  wire sat_lvl_pkg::findflag_t  findflag_i,
    output sat_lvl_pkg::findflag_t       findflag_o,
    output logic [1:0]                   hit_o,
    output sat_lvl_pkg::bin_t            bkt_bin_o,
    output sat_lvl_pkg::lvl_state_t [1:0] states_o
);

    import sat_lvl_pkg::*;

    findflag_t mid_flag;  // between upper and lower cell.
    bin_t      bin_hi;
    bin_t      bin_lo;

    lvl_state_cell u_cell_hi (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dcd_wr_i    (dcd_wr_i[1]),
        .dcd_bin_i   (dcd_bin_i),
        .ld_wr_i     (ld_wr_i[1]),
        .ld_state_i  (ld_state_i),
        .apply_bkt_i (apply_bkt_i),
        .in_range_i  (in_range_i[1]),
        .findflag_i  (findflag_i),
        .findflag_o  (mid_flag),
        .hit_o       (hit_o[1]),
        .bkt_bin_o   (bin_hi),
        .state_o     (states_o[1])
    );

    lvl_state_cell u_cell_lo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dcd_wr_i    (dcd_wr_i[0]),
        .dcd_bin_i   (dcd_bin_i),
        .ld_wr_i     (ld_wr_i[0]),
        .ld_state_i  (ld_state_i),
        .apply_bkt_i (apply_bkt_i),
        .in_range_i  (in_range_i[0]),
        .findflag_i  (mid_flag),
        .findflag_o  (findflag_o),
        .hit_o       (hit_o[0]),
        .bkt_bin_o   (bin_lo),
        .state_o     (states_o[0])
    );

    assign bkt_bin_o = bin_hi | bin_lo;  // at most one cell drives a bin.

endmodule

`default_nettype wire

// File: src/bkt_result.sv
// Registers the backtrack outcome one cycle after the apply, plus the level readback.
// Result payload is only meaningful while bkt_done_o is high.
`timescale 1ns/1ps
`default_nettype none

module bkt_result (
    input  wire                                         clk,
    input  wire                                         rst_n_i,
    input  wire                                         apply_bkt_i,
    input  wire sat_lvl_pkg::findflag_t                 findflag_i,
    input  wire sat_lvl_pkg::lvl_mask_t                 hit_i,
    input  wire sat_lvl_pkg::bin_t                      bkt_bin_i,
    input  wire sat_lvl_pkg::lvl_state_t [sat_lvl_pkg::NUM_LVLS-1:0] states_i,
    input  wire sat_lvl_pkg::lvl_t                      rd_lvl_i,
    output logic                                        bkt_done_o,
    output logic                                        unsat_o,
    output sat_lvl_pkg::lvl_t                           bkt_lvl_o,
    output sat_lvl_pkg::bin_t                           bkt_bin_o,
    output sat_lvl_pkg::lvl_state_t                     rd_state_o
);

    import sat_lvl_pkg::*;

    lvl_t hit_lvl;
    logic cap_vld_q;    // a backtrack was applied last edge.
    logic cap_found_q;
    lvl_t cap_lvl_q;
    bin_t cap_bin_q;
    lvl_t rd_lvl_q;

    always_comb begin
        hit_lvl = '0;
        for (int i = 0; i < NUM_LVLS; i++) begin
            if (hit_i[i]) begin
                hit_lvl = hit_lvl | lvl_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cap_vld_q   <= 1'b0;
            cap_found_q <= 1'b0;
            bkt_done_o  <= 1'b0;
            unsat_o     <= 1'b0;
        end else begin
            cap_vld_q   <= apply_bkt_i;
            cap_found_q <= (findflag_i != FIND_SEARCH);  // flag out of level 0.
            bkt_done_o  <= cap_vld_q && cap_found_q;
            unsat_o     <= cap_vld_q && !cap_found_q;
        end
    end

    always_ff @(posedge clk) begin
        if (apply_bkt_i) begin
            cap_lvl_q <= hit_lvl;
            cap_bin_q <= bkt_bin_i;
        end
        if (cap_vld_q && cap_found_q) begin
            bkt_lvl_o <= cap_lvl_q;
            bkt_bin_o <= cap_bin_q;
        end
        rd_lvl_q   <= rd_lvl_i;
        rd_state_o <= states_i[rd_lvl_q];
    end

endmodule

`default_nettype wire

// File: src/lvl_state_top.sv
// Level-state store: command decode, a chain of level pairs and the result stage.
// All requests are single-cycle strobes with no back-pressure.
`timescale 1ns/1ps
`default_nettype none

module lvl_state_top (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          decide_i,
    input  wire sat_lvl_pkg::lvl_t       dcd_lvl_i,
    input  wire sat_lvl_pkg::bin_t       dcd_bin_i,
    input  wire                          bkt_req_i,
    input  wire sat_lvl_pkg::lvl_t       max_lvl_i,
    input  wire                          ld_i,
    input  wire sat_lvl_pkg::lvl_t       ld_lvl_i,
    input  wire sat_lvl_pkg::lvl_state_t ld_state_i,
    input  wire sat_lvl_pkg::lvl_t       rd_lvl_i,
    output logic                         bkt_done_o,
    output logic                         unsat_o,
    output sat_lvl_pkg::lvl_t            bkt_lvl_o,
    output sat_lvl_pkg::bin_t            bkt_bin_o,
    output sat_lvl_pkg::lvl_state_t      rd_state_o
);

    import sat_lvl_pkg::*;

    lvl_mask_t                     dcd_wr;
    bin_t                          dcd_bin;
    lvl_mask_t                     ld_wr;
    lvl_state_t                    ld_state;
    logic                          apply_bkt;
    lvl_mask_t                     in_range;
    lvl_mask_t                     hit;
    findflag_t [NUM_PAIRS:0]       flag_chain;  // index p enters pair p-1.
    bin_t      [NUM_PAIRS-1:0]     pair_bin;
    bin_t                          bkt_bin;
    lvl_state_t [NUM_LVLS-1:0]     states;

    lvl_cmd_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .decide_i    (decide_i),
        .dcd_lvl_i   (dcd_lvl_i),
        .dcd_bin_i   (dcd_bin_i),
        .bkt_req_i   (bkt_req_i),
        .max_lvl_i   (max_lvl_i),
        .ld_i        (ld_i),
        .ld_lvl_i    (ld_lvl_i),
        .ld_state_i  (ld_state_i),
        .dcd_wr_o    (dcd_wr),
        .dcd_bin_o   (dcd_bin),
        .ld_wr_o     (ld_wr),
        .ld_state_o  (ld_state),
        .apply_bkt_o (apply_bkt),
        .in_range_o  (in_range)
    );

    assign flag_chain[NUM_PAIRS] = FIND_SEARCH;

    for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_pair
        lvl_state2 u_pair (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .dcd_wr_i    (dcd_wr[2*p +: 2]),
            .dcd_bin_i   (dcd_bin),
            .ld_wr_i     (ld_wr[2*p +: 2]),
            .ld_state_i  (ld_state),
            .apply_bkt_i (apply_bkt),
            .in_range_i  (in_range[2*p +: 2]),
            .findflag_i  (flag_chain[p+1]),
            .findflag_o  (flag_chain[p]),
            .hit_o       (hit[2*p +: 2]),
            .bkt_bin_o   (pair_bin[p]),
            .states_o    (states[2*p +: 2])
        );
    end

    always_comb begin
        bkt_bin = '0;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            bkt_bin = bkt_bin | pair_bin[p];
        end
    end

    bkt_result u_result (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .apply_bkt_i (apply_bkt),
        .findflag_i  (flag_chain[0]),
        .hit_i       (hit),
        .bkt_bin_i   (bkt_bin),
        .states_i    (states),
        .rd_lvl_i    (rd_lvl_i),
        .bkt_done_o  (bkt_done_o),
        .unsat_o     (unsat_o),
        .bkt_lvl_o   (bkt_lvl_o),
        .bkt_bin_o   (bkt_bin_o),
        .rd_state_o  (rd_state_o)
    );

endmodule

`default_nettype wire

// File: test/lvl_state_asserts.sv
// Timing and one-hot checks of the level-state store, bound into the top level.
`timescale 1ns/1ps
`default_nettype none

module lvl_state_asserts (
    input wire                         clk,
    input wire                         rst_n_i,
    input wire                         decide_i,
    input wire sat_lvl_pkg::lvl_t      dcd_lvl_i,
    input wire                         ld_i,
    input wire sat_lvl_pkg::lvl_t      ld_lvl_i,
    input wire sat_lvl_pkg::lvl_t      max_lvl_i,
    input wire                         apply_bkt_i,
    input wire sat_lvl_pkg::findflag_t flag_i,
    input wire sat_lvl_pkg::lvl_mask_t hit_i,
    input wire sat_lvl_pkg::lvl_mask_t dcd_wr_i,
    input wire sat_lvl_pkg::lvl_mask_t ld_wr_i,
    input wire sat_lvl_pkg::lvl_mask_t in_range_i,
    input wire                         bkt_done_i,
    input wire                         unsat_i
);

    import sat_lvl_pkg::*;

    int fail_cnt = 0;  // failed assertions so far.

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(hit_i) && ((hit_i != '0) == (flag_i != FIND_SEARCH)))
        else begin
            fail_cnt++;
            $error("hit vector not one-hot or not matching the find flag");
        end

    // strobes are one-hot copies of the requests sampled one edge earlier.
    a_dcd_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
        dcd_wr_i == ($past(decide_i) ? lvl_mask_t'(1) << $past(dcd_lvl_i) : '0))
        else begin
            fail_cnt++;
            $error("decide strobe does not match the request");
        end

    a_ld_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
        ld_wr_i == (($past(ld_i) && !($past(decide_i) && $past(dcd_lvl_i) == $past(ld_lvl_i)))
                    ? lvl_mask_t'(1) << $past(ld_lvl_i) : '0))
        else begin
            fail_cnt++;
            $error("load strobe does not match the request or the decide priority");
        end

    // the range mask covers level 0 up to the max level sampled one edge earlier.
    a_range_mask: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> in_range_i == lvl_mask_t'((16'd2 << $past(max_lvl_i)) - 16'd1))
        else begin
            fail_cnt++;
            $error("range mask does not cover exactly the levels up to the max level");
        end

    a_pulse_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(bkt_done_i && unsat_i))
        else begin
            fail_cnt++;
            $error("bkt_done and unsat high together");
        end

    a_apply_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(apply_bkt_i, 2) == (bkt_done_i || unsat_i))
        else begin
            fail_cnt++;
            $error("backtrack response not two cycles after apply");
        end

    a_unsat_when_none: assert property (@(posedge clk) disable iff (!rst_n_i)
        ($past(apply_bkt_i, 2) && ($past(flag_i, 2) == FIND_SEARCH)) |-> unsat_i)
        else begin
            fail_cnt++;
            $error("no level found but unsat did not pulse");
        end

endmodule

bind lvl_state_top lvl_state_asserts u_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .decide_i    (decide_i),
    .dcd_lvl_i   (dcd_lvl_i),
    .ld_i        (ld_i),
    .ld_lvl_i    (ld_lvl_i),
    .max_lvl_i   (max_lvl_i),
    .apply_bkt_i (apply_bkt),
    .flag_i      (flag_chain[0]),
    .hit_i       (hit),
    .dcd_wr_i    (dcd_wr),
    .ld_wr_i     (ld_wr),
    .in_range_i  (in_range),
    .bkt_done_i  (bkt_done_o),
    .unsat_i     (unsat_o)
);

`default_nettype wire

// File: test/lvl_state_tb.sv
// Testbench of the level-state store with directed and LFSR stimulus against a reference model.
// Backtrack outcomes are matched in order through a queue of expected results.
`timescale 1ns/1ps
`default_nettype none

module lvl_state_tb;

    import sat_lvl_pkg::*;

    typedef struct packed {
        logic found;
        lvl_t lvl;
        bin_t bin;
    } bkt_exp_t;

    localparam int TEST_CYCLES = 200;
    localparam int WATCHDOG_NS = TEST_CYCLES * 40 + 2000;

    logic       clk = 1'b0;
    logic       rst_n_i = 1'b0;
    logic       decide_i;
    logic       bkt_req_i;
    logic       ld_i;
    lvl_t       dcd_lvl_i;
    lvl_t       max_lvl_i;
    lvl_t       ld_lvl_i;
    lvl_t       rd_lvl_i;
    bin_t       dcd_bin_i;
    lvl_state_t ld_state_i;
    logic       bkt_done_o;
    logic       unsat_o;
    lvl_t       bkt_lvl_o;
    bin_t       bkt_bin_o;
    lvl_state_t rd_state_o;

    bin_t        model_bin [NUM_LVLS];
    logic        model_bkt [NUM_LVLS];
    bkt_exp_t    exp_q [$];
    logic [31:0] lfsr_q = 32'd66443;
    int          chk_cnt = 0;
    int          err_cnt = 0;

    always #20 clk = ~clk;

    lvl_state_top dut (
        .clk (clk), .rst_n_i (rst_n_i),
        .decide_i (decide_i), .dcd_lvl_i (dcd_lvl_i), .dcd_bin_i (dcd_bin_i),
        .bkt_req_i (bkt_req_i), .max_lvl_i (max_lvl_i),
        .ld_i (ld_i), .ld_lvl_i (ld_lvl_i), .ld_state_i (ld_state_i), .rd_lvl_i (rd_lvl_i),
        .bkt_done_o (bkt_done_o), .unsat_o (unsat_o), .bkt_lvl_o (bkt_lvl_o),
        .bkt_bin_o (bkt_bin_o), .rd_state_o (rd_state_o)
    );

    // Galois form of x^32 + x^22 + x^2 + x + 1, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    // one write cycle; when both strobes target the level the decide wins.
    task automatic write_level(input lvl_t l, input logic dcd, input bin_t b,
                               input logic ld, input lvl_state_t s);
        @(posedge clk);
        decide_i   <= dcd;
        dcd_lvl_i  <= l;
        dcd_bin_i  <= b;
        ld_i       <= ld;
        ld_lvl_i   <= l;
        ld_state_i <= s;
        @(posedge clk);
        decide_i <= 1'b0;
        ld_i     <= 1'b0;
        if (dcd) begin
            model_bin[l] = b;
            model_bkt[l] = 1'b0;
        end else if (ld) begin
            model_bin[l] = s.dcd_bin;
            model_bkt[l] = s.has_bkt;
        end
    endtask

    task automatic read_check(input lvl_t l);
        @(posedge clk);
        rd_lvl_i <= l;
        repeat (2) @(posedge clk);  // sampled, then registered behind the state.
        @(negedge clk);
        check_val("rd_state_o", 32'(rd_state_o), 32'({model_bin[l], model_bkt[l]}));
    endtask

    task automatic backtrack(input lvl_t m);
        bkt_exp_t e;
        int       n;
        e = '0;
        for (int i = NUM_LVLS - 1; i >= 0; i--) begin
            if (!e.found && (lvl_t'(i) <= m) && !model_bkt[i]) begin
                e.found = 1'b1;
                e.lvl   = lvl_t'(i);
                e.bin   = model_bin[i];
            end
        end
        if (e.found) begin
            model_bkt[e.lvl] = 1'b1;
        end
        exp_q.push_back(e);
        @(posedge clk);
        bkt_req_i <= 1'b1;
        max_lvl_i <= m;
        @(posedge clk);
        bkt_req_i <= 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 8) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("backtrack with max level %0d got neither a done nor an unsat pulse", m);
            exp_q.delete();
        end
    endtask

    always @(negedge clk) begin
        bkt_exp_t e;
        if (rst_n_i && (bkt_done_o || unsat_o)) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("backtrack result pulse at %0t ns with no request pending", $time);
            end else begin
                e = exp_q.pop_front();
                check_val("bkt_done_o", 32'(bkt_done_o), 32'(e.found));
                check_val("unsat_o", 32'(unsat_o), 32'(!e.found));
                if (e.found) begin
                    check_val("bkt_lvl_o", 32'(bkt_lvl_o), 32'(e.lvl));
                    check_val("bkt_bin_o", 32'(bkt_bin_o), 32'(e.bin));
                end
            end
        end
    end

    initial begin
        int         e0;
        lvl_t       m;
        lvl_state_t s;
        decide_i   = 1'b0;
        bkt_req_i  = 1'b0;
        ld_i       = 1'b0;
        dcd_lvl_i  = '0;
        max_lvl_i  = '0;
        ld_lvl_i   = '0;
        rd_lvl_i   = '0;
        dcd_bin_i  = '0;
        ld_state_i = '0;
        for (int i = 0; i < NUM_LVLS; i++) begin
            model_bin[i] = '0;
            model_bkt[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        e0 = err_cnt;
        for (int i = 0; i < NUM_LVLS; i++) read_check(lvl_t'(i));
        $display("test 1 reset readback: %0d errors", err_cnt - e0);

        e0 = err_cnt;
        for (int i = 0; i < NUM_LVLS; i++) begin
            write_level(lvl_t'(i), 1'b1, bin_t'(take_bits(WIDTH_BIN)), 1'b0, '0);
        end
        for (int i = 0; i < 4; i++) read_check(lvl_t'(take_bits(WIDTH_LVL)));
        $display("test 2 decide and readback: %0d errors", err_cnt - e0);

        e0 = err_cnt;
        backtrack(3'd7);
        read_check(3'd7);
        backtrack(3'd7);
        read_check(3'd6);
        m = lvl_t'(take_bits(WIDTH_LVL));
        backtrack(m);
        read_check(m);
        $display("test 3 backtrack deepest level: %0d errors", err_cnt - e0);

        e0 = err_cnt;
        backtrack(3'd3);  // level 4 or 5 is still clear above the limit.
        read_check(3'd3);
        $display("test 4 levels above max skipped: %0d errors", err_cnt - e0);

        e0 = err_cnt;
        repeat (3) backtrack(3'd1);
        read_check(3'd0);
        read_check(3'd1);
        $display("test 5 unsat when none left: %0d errors", err_cnt - e0);

        e0 = err_cnt;
        for (int i = 0; i < 4; i++) begin
            s = lvl_state_t'(take_bits(WIDTH_BIN + 1));
            write_level(lvl_t'(i), 1'b0, '0, 1'b1, s);
        end
        for (int i = 0; i < 4; i++) read_check(lvl_t'(i));
        s = lvl_state_t'(take_bits(WIDTH_BIN + 1));
        write_level(3'd2, 1'b1, bin_t'(take_bits(WIDTH_BIN)), 1'b1, s);
        read_check(3'd2);
        backtrack(3'd3);
        $display("test 6 load restore and decide priority: %0d errors", err_cnt - e0);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 chk_cnt, err_cnt, dut.u_asserts.fail_cnt);
        if (err_cnt == 0 && dut.u_asserts.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: lvl_state_top.f
common/sat_lvl_pkg.sv
src/lvl_cmd_decode.sv
lvl_state/lvl_state_cell.sv
lvl_state/lvl_state2.sv
src/bkt_result.sv
src/lvl_state_top.sv
test/lvl_state_asserts.sv
test/lvl_state_tb.sv

// File: run.sh
#!/bin/sh
# Compiles the level-state store testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --top-module lvl_state_tb \
        -f lvl_state_top.f --Mdir "$BUILD_DIR" -o sim_lvl_state; then
    echo "verilator compile failed"
    exit 1
fi

if ! "./$BUILD_DIR/sim_lvl_state" +verilator+error+limit+100 > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
